// ==== verilog/stats_defs.svh ====
// statistics block sizing macros: channel counts, field widths and update period
`default_nettype none

`ifndef STATS_DEFS_SVH
`define STATS_DEFS_SVH

// channels owned by one collector.
`define STATS_GROUP_CNT 8

// channels over the whole block.
`define STATS_CH_CNT 16

// per-source increment and per-record increment.
`define STATS_INC_W 8
`define STATS_REC_W 16

// statistic id covers every channel.
`define STATS_ID_W 4

`define STATS_CNT_W 32

// cycles between timed flushes.
`define STATS_UPDATE_PERIOD 256

`endif

`default_nettype wire

// ==== verilog/stats_pkg.sv ====
// stats_pkg: record, read request, read response and FSM state types
`include "stats_defs.svh"
`default_nettype none

package stats_pkg;

    // one flushed total for one statistic.
    typedef struct packed {
        logic [`STATS_ID_W-1:0]  id;
        logic [`STATS_REC_W-1:0] inc;
    } stat_rec_t;

    // host asks for one counter.
    typedef struct packed {
        logic [`STATS_ID_W-1:0] id;
    } rd_req_t;

    typedef struct packed {
        logic [`STATS_ID_W-1:0]  id;
        logic [`STATS_CNT_W-1:0] value;
    } rd_resp_t;

    // collector visits a channel in two steps.
    typedef enum logic {
        scan_read,
        scan_write
    } scan_state_e;

    typedef enum logic [1:0] {
        ctr_init,   // zero sweep after reset.
        ctr_idle,
        ctr_add,    // write back of a record add.
        ctr_read    // host read in flight.
    } ctr_state_e;

endpackage

`default_nettype wire

// ==== verilog/stats_collect.sv ====
// stats_collect: channel accumulators, holding memory, scan FSM and record flush
`timescale 1ns/1ps
`include "stats_defs.svh"
`default_nettype none

module stats_collect #(
    parameter int id_base = 0
) (
    input  wire logic                                          clk,
    input  wire logic                                          rst,
    input  wire logic [`STATS_GROUP_CNT-1:0][`STATS_INC_W-1:0] stat_inc,
    input  wire logic [`STATS_GROUP_CNT-1:0]                   stat_valid,
    input  wire logic                                          update,
    output stats_pkg::stat_rec_t                               rec,
    output logic                                               rec_valid,
    input  wire logic                                          rec_ready
);

    localparam int ch_n     = `STATS_GROUP_CNT;
    localparam int ch_w     = $clog2(ch_n);
    localparam int acc_w    = `STATS_INC_W + ch_w + 1;  // holds 2*ch_n max increments.
    localparam int rec_w    = `STATS_REC_W;
    localparam int id_w     = `STATS_ID_W;
    localparam int period_w = $clog2(`STATS_UPDATE_PERIOD + 1);

    stats_pkg::scan_state_e state;
    logic [ch_w-1:0]        ch_idx;
    logic [period_w-1:0]    period_cnt;
    logic                   first_pass;     // memory not yet written.
    logic                   update_req;
    logic                   flush_armed;    // current pass flushes.
    logic [ch_n-1:0]        pending;        // rotates with the scan.

    logic [acc_w-1:0] acc [ch_n];
    logic [ch_n-1:0]  acc_clear;
    logic [acc_w-1:0] acc_val;
    logic [rec_w-1:0] held_mem [ch_n];
    logic [rec_w-1:0] held_rd;
    logic [rec_w-1:0] sum;
    logic [rec_w-1:0] mem_wr_data;
    logic             flush_due;
    logic             flush_now;
    logic             pass_end;

    for (genvar n = 0; n < ch_n; n++) begin : g_acc
        logic [acc_w-1:0] acc_q;

        assign acc[n] = acc_q;

        always_ff @(posedge clk) begin
            if (rst) begin
                acc_q <= '0;
            end else if (acc_clear[n]) begin
                // same-cycle increment starts the next sum.
                acc_q <= stat_valid[n] ? acc_w'(stat_inc[n]) : '0;
            end else if (stat_valid[n]) begin
                acc_q <= acc_q + acc_w'(stat_inc[n]);
            end
        end
    end

    always_comb begin
        acc_clear = '0;
        acc_clear[ch_idx] = (state == stats_pkg::scan_read);
    end

    assign sum       = held_rd + rec_w'(acc_val);
    assign flush_due = flush_armed || pending[0];
    assign flush_now = (state == stats_pkg::scan_write) && !first_pass && !rec_valid && flush_due;
    assign pass_end  = (state == stats_pkg::scan_write) && (ch_idx == ch_w'(ch_n - 1));

    always_comb begin
        if (first_pass) begin
            mem_wr_data = rec_w'(acc_val);
        end else if (flush_now) begin
            mem_wr_data = '0;
        end else begin
            mem_wr_data = sum;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= stats_pkg::scan_read;
            ch_idx      <= '0;
            period_cnt  <= period_w'(`STATS_UPDATE_PERIOD - 1);
            first_pass  <= 1'b1;
            update_req  <= 1'b0;
            flush_armed <= 1'b0;
            pending     <= '0;
            rec_valid   <= 1'b0;
        end else begin
            if (rec_ready) begin
                rec_valid <= 1'b0;
            end

            if (state == stats_pkg::scan_read) begin
                state <= stats_pkg::scan_write;
            end else begin
                state <= stats_pkg::scan_read;
                if (flush_now) begin
                    rec_valid <= (sum != '0);   // nothing to send for a zero total.
                    pending   <= {1'b0, pending[ch_n-1:1]};
                end else begin
                    pending   <= {flush_due, pending[ch_n-1:1]};  // retry next pass.
                end

                if (pass_end) begin
                    ch_idx      <= '0;
                    first_pass  <= 1'b0;
                    flush_armed <= update_req;
                    update_req  <= 1'b0;
                end else begin
                    ch_idx <= ch_idx + 1'b1;
                end
            end

            // a new request wins over the clear at pass end.
            if (period_cnt == '0 || update) begin
                update_req <= 1'b1;
                period_cnt <= period_w'(`STATS_UPDATE_PERIOD - 1);
            end else begin
                period_cnt <= period_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == stats_pkg::scan_read) begin
            acc_val <= acc[ch_idx];
            held_rd <= held_mem[ch_idx];
        end else begin
            held_mem[ch_idx] <= mem_wr_data;
        end

        if (flush_now) begin
            rec.id  <= id_w'(id_base + int'(ch_idx));
            rec.inc <= sum;
        end
    end

    a_rec_stable: assert property (@(posedge clk) disable iff (rst)
        rec_valid && !rec_ready |=> rec_valid && $stable(rec));

endmodule

`default_nettype wire

// ==== verilog/stats_arb.sv ====
// stats_arb: two-input round-robin record arbiter with a registered output
`timescale 1ns/1ps
`default_nettype none

module stats_arb (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire stats_pkg::stat_rec_t in_rec [2],
    input  wire logic [1:0]           in_valid,
    output logic [1:0]                in_ready,
    output stats_pkg::stat_rec_t      out_rec,
    output logic                      out_valid,
    input  wire logic                 out_ready
);

    logic prio;     // input favoured on a tie.
    logic load;
    logic sel;
    logic grant;

    assign load  = !out_valid || out_ready;    // empty or draining.
    assign sel   = in_valid[prio] ? prio : !prio;
    assign grant = load && (in_valid != 2'b00);

    always_comb begin
        in_ready = 2'b00;
        in_ready[sel] = grant;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            prio      <= 1'b0;
        end else if (grant) begin
            out_valid <= 1'b1;
            prio      <= !sel;  // move past the winner.
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            out_rec <= in_rec[sel];
        end
    end

    // two waiting inputs take turns.
    a_alternate: assert property (@(posedge clk) disable iff (rst)
        in_valid == 2'b11 && grant
        |=> !(in_valid == 2'b11 && grant) || in_ready != $past(in_ready));

endmodule

`default_nettype wire

// ==== verilog/stats_counter.sv ====
// stats_counter: counter memory with record add, clear sweep and host read port
`timescale 1ns/1ps
`include "stats_defs.svh"
`default_nettype none

module stats_counter (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire stats_pkg::stat_rec_t rec,
    input  wire logic                 rec_valid,
    output logic                      rec_ready,
    input  wire stats_pkg::rd_req_t   rd_req,
    input  wire logic                 rd_req_valid,
    output logic                      rd_req_ready,
    output stats_pkg::rd_resp_t       rd_resp,
    output logic                      rd_resp_valid,
    input  wire logic                 rd_resp_ready
);

    localparam int ch_n  = `STATS_CH_CNT;
    localparam int id_w  = `STATS_ID_W;
    localparam int cnt_w = `STATS_CNT_W;

    stats_pkg::ctr_state_e state;
    logic [id_w-1:0]         init_idx;
    logic [cnt_w-1:0]        cnt_mem [ch_n];
    logic [id_w-1:0]         op_id;
    logic [`STATS_REC_W-1:0] add_inc;
    logic [cnt_w-1:0]        add_old;
    logic                    rec_take;
    logic                    req_take;
    logic                    mem_wr_en;
    logic [id_w-1:0]         mem_wr_addr;
    logic [cnt_w-1:0]        mem_wr_data;

    // records go first, and one response waits at a time.
    assign rec_ready    = (state == stats_pkg::ctr_idle);
    assign rd_req_ready = (state == stats_pkg::ctr_idle) && !rec_valid && !rd_resp_valid;
    assign rec_take     = rec_valid && rec_ready;
    assign req_take     = rd_req_valid && rd_req_ready;

    always_comb begin
        mem_wr_en   = 1'b0;
        mem_wr_addr = op_id;
        mem_wr_data = add_old + cnt_w'(add_inc);   // wraps modulo 2^32.
        if (state == stats_pkg::ctr_init) begin
            mem_wr_en   = 1'b1;
            mem_wr_addr = init_idx;
            mem_wr_data = '0;
        end else if (state == stats_pkg::ctr_add) begin
            mem_wr_en = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= stats_pkg::ctr_init;
            init_idx      <= '0;
            rd_resp_valid <= 1'b0;
        end else begin
            if (rd_resp_ready) begin
                rd_resp_valid <= 1'b0;
            end

            case (state)
                stats_pkg::ctr_init: begin
                    init_idx <= init_idx + 1'b1;
                    if (init_idx == id_w'(ch_n - 1)) begin
                        state <= stats_pkg::ctr_idle;
                    end
                end
                stats_pkg::ctr_idle: begin
                    if (rec_take) begin
                        state <= stats_pkg::ctr_add;
                    end else if (req_take) begin
                        state <= stats_pkg::ctr_read;
                    end
                end
                stats_pkg::ctr_add: begin
                    state <= stats_pkg::ctr_idle;
                end
                stats_pkg::ctr_read: begin
                    rd_resp_valid <= 1'b1;
                    state         <= stats_pkg::ctr_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wr_en) begin
            cnt_mem[mem_wr_addr] <= mem_wr_data;
        end

        // read half of the add happens on accept.
        if (rec_take) begin
            op_id   <= rec.id;
            add_inc <= rec.inc;
            add_old <= cnt_mem[rec.id];
        end else if (req_take) begin
            op_id <= rd_req.id;
        end

        if (state == stats_pkg::ctr_read) begin
            rd_resp.id    <= op_id;
            rd_resp.value <= cnt_mem[op_id];
        end
    end

    a_resp_hold: assert property (@(posedge clk) disable iff (rst)
        rd_resp_valid && !rd_resp_ready |=> rd_resp_valid && $stable(rd_resp));

endmodule

`default_nettype wire

// ==== verilog/stats_top.sv ====
// stats_top: two collectors, record arbiter and counter bank
`timescale 1ns/1ps
`include "stats_defs.svh"
`default_nettype none

module stats_top (
    input  wire logic                                       clk,
    input  wire logic                                       rst,
    input  wire logic [`STATS_CH_CNT-1:0][`STATS_INC_W-1:0] stat_inc,
    input  wire logic [`STATS_CH_CNT-1:0]                   stat_valid,
    input  wire logic                                       update,
    input  wire stats_pkg::rd_req_t                         rd_req,
    input  wire logic                                       rd_req_valid,
    output logic                                            rd_req_ready,
    output stats_pkg::rd_resp_t                             rd_resp,
    output logic                                            rd_resp_valid,
    input  wire logic                                       rd_resp_ready
);

    localparam int grp_n = `STATS_GROUP_CNT;

    stats_pkg::stat_rec_t grp_rec [2];
    logic [1:0]           grp_valid;
    logic [1:0]           grp_ready;
    stats_pkg::stat_rec_t arb_rec;
    logic                 arb_valid;
    logic                 arb_ready;

    // lanes 0..7.
    stats_collect #(.id_base(0)) i_collect_0 (
        .clk        (clk),
        .rst        (rst),
        .stat_inc   (stat_inc[grp_n-1:0]),
        .stat_valid (stat_valid[grp_n-1:0]),
        .update     (update),
        .rec        (grp_rec[0]),
        .rec_valid  (grp_valid[0]),
        .rec_ready  (grp_ready[0])
    );

    // lanes 8..15.
    stats_collect #(.id_base(grp_n)) i_collect_1 (
        .clk        (clk),
        .rst        (rst),
        .stat_inc   (stat_inc[2*grp_n-1:grp_n]),
        .stat_valid (stat_valid[2*grp_n-1:grp_n]),
        .update     (update),
        .rec        (grp_rec[1]),
        .rec_valid  (grp_valid[1]),
        .rec_ready  (grp_ready[1])
    );

    stats_arb i_arb (
        .clk       (clk),
        .rst       (rst),
        .in_rec    (grp_rec),
        .in_valid  (grp_valid),
        .in_ready  (grp_ready),
        .out_rec   (arb_rec),
        .out_valid (arb_valid),
        .out_ready (arb_ready)
    );

    stats_counter i_counter (
        .clk           (clk),
        .rst           (rst),
        .rec           (arb_rec),
        .rec_valid     (arb_valid),
        .rec_ready     (arb_ready),
        .rd_req        (rd_req),
        .rd_req_valid  (rd_req_valid),
        .rd_req_ready  (rd_req_ready),
        .rd_resp       (rd_resp),
        .rd_resp_valid (rd_resp_valid),
        .rd_resp_ready (rd_resp_ready)
    );

endmodule

`default_nettype wire

// ==== dv/stats_tb.sv ====
// testbench for the statistics block: LFSR traffic, reference sums, read-back assertions
`timescale 1ns/1ps
`include "stats_defs.svh"
`default_nettype none

module stats_tb;

    localparam int ch_n        = `STATS_CH_CNT;
    localparam int drain_cyc   = 2000;
    localparam int read_round  = ch_n * 24;    // loose bound for one sweep of reads.
    localparam int t1_len      = 32 + read_round;
    localparam int t2_len      = 600 + drain_cyc + read_round;
    localparam int t3_len      = 440 + drain_cyc + read_round;
    localparam int t4_len      = 300 + 3 * `STATS_UPDATE_PERIOD + drain_cyc + read_round;
    localparam int t5_len      = 600 + 6 * read_round + drain_cyc + read_round;
    localparam int cycle_limit = t1_len + t2_len + t3_len + t4_len + t5_len + 1000;

    logic                                       clk;
    logic                                       rst;
    logic [`STATS_CH_CNT-1:0][`STATS_INC_W-1:0] stat_inc;
    logic [`STATS_CH_CNT-1:0]                   stat_valid;
    logic                                       update;
    stats_pkg::rd_req_t                         rd_req;
    logic                                       rd_req_valid;
    logic                                       rd_req_ready;
    stats_pkg::rd_resp_t                        rd_resp;
    logic                                       rd_resp_valid;
    logic                                       rd_resp_ready;

    logic [15:0]             lfsr;
    logic [`STATS_CNT_W-1:0] ref_sum [ch_n];   // wraps like the counters.
    logic [`STATS_ID_W-1:0]  exp_id;
    logic                    check_value;      // off while counters still lag.
    int                      error_cnt;
    int                      read_cnt;
    int                      test_no;
    int                      err_mark;
    int                      cycle_cnt;

    stats_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .stat_inc      (stat_inc),
        .stat_valid    (stat_valid),
        .update        (update),
        .rd_req        (rd_req),
        .rd_req_valid  (rd_req_valid),
        .rd_req_ready  (rd_req_ready),
        .rd_resp       (rd_resp),
        .rd_resp_valid (rd_resp_valid),
        .rd_resp_ready (rd_resp_ready)
    );

    always #20 clk = ~clk;

    a_resp_value: assert property (@(posedge clk) disable iff (rst)
        rd_resp_valid && rd_resp_ready && check_value |-> rd_resp.value == ref_sum[rd_resp.id])
    else begin
        error_cnt++;
        $display("FAIL t=%0t counter %0d reads %0h, expected %0h", $time, rd_resp.id,
                 rd_resp.value, ref_sum[rd_resp.id]);
    end

    a_resp_id: assert property (@(posedge clk) disable iff (rst)
        rd_resp_valid |-> rd_resp.id == exp_id)
    else begin
        error_cnt++;
        $display("FAIL t=%0t response id %0d, expected %0d", $time, rd_resp.id, exp_id);
    end

    a_resp_hold: assert property (@(posedge clk) disable iff (rst)
        rd_resp_valid && !rd_resp_ready |=> rd_resp_valid && $stable(rd_resp))
    else begin
        error_cnt++;
        $display("t=%0t: read response was dropped or changed before it was accepted", $time);
    end

    // galois lfsr with taps for x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic rand_bit();
        logic out;
        out = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 16'hb400;
        end
        return out;
    endfunction

    function automatic logic [`STATS_INC_W-1:0] rand_inc();
        logic [`STATS_INC_W-1:0] v;
        for (int i = 0; i < `STATS_INC_W; i++) begin
            v[i] = rand_bit();
        end
        return v;
    endfunction

    // random increments on enabled lanes and nonzero junk on disabled ones.
    task automatic drive_traffic(input int cycles, input logic [ch_n-1:0] lane_en,
                                 input logic rand_ready);
        logic [`STATS_CH_CNT-1:0][`STATS_INC_W-1:0] inc_vec;
        logic [`STATS_CH_CNT-1:0]                   valid_vec;
        repeat (cycles) begin
            @(posedge clk);
            for (int n = 0; n < ch_n; n++) begin
                inc_vec[n] = rand_inc();
                valid_vec[n] = rand_bit() && lane_en[n];
                if (!lane_en[n]) begin
                    inc_vec[n][0] = 1'b1;
                end
                if (valid_vec[n]) begin
                    ref_sum[n] = ref_sum[n] + `STATS_CNT_W'(inc_vec[n]);
                end
            end
            stat_inc   <= inc_vec;
            stat_valid <= valid_vec;
            if (rand_ready) begin
                rd_resp_ready <= rand_bit();
            end
        end
        @(posedge clk);
        stat_valid    <= '0;
        rd_resp_ready <= 1'b1;
    endtask

    task automatic pulse_update();
        @(posedge clk);
        update <= 1'b1;
        @(posedge clk);
        update <= 1'b0;
    endtask

    task automatic drain();
        repeat (drain_cyc) @(posedge clk);
    endtask

    // one request and a wait until its response is taken.
    task automatic read_counter(input logic [`STATS_ID_W-1:0] id);
        @(posedge clk);
        rd_req.id    <= id;
        rd_req_valid <= 1'b1;
        exp_id       <= id;
        @(negedge clk);
        while (!rd_req_ready) @(negedge clk);
        @(posedge clk);
        rd_req_valid <= 1'b0;
        @(negedge clk);
        while (!(rd_resp_valid && rd_resp_ready)) @(negedge clk);
        @(posedge clk);
        read_cnt++;
    endtask

    task automatic read_all();
        for (int n = 0; n < ch_n; n++) begin
            read_counter(`STATS_ID_W'(n));
        end
    endtask

    task automatic start_test();
        test_no++;
        err_mark = error_cnt;
    endtask

    task automatic end_test(input string name);
        $display("test %0d %s: %0d errors", test_no, name, error_cnt - err_mark);
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        stat_inc      = '0;
        stat_valid    = '0;
        update        = 1'b0;
        rd_req        = '0;
        rd_req_valid  = 1'b0;
        rd_resp_ready = 1'b0;
        lfsr          = 16'd52;
        exp_id        = '0;
        check_value   = 1'b1;
        error_cnt     = 0;
        read_cnt      = 0;
        test_no       = 0;
        for (int n = 0; n < ch_n; n++) begin
            ref_sum[n] = '0;
        end
        repeat (16) @(posedge clk);
        rst           <= 1'b0;
        rd_resp_ready <= 1'b1;

        start_test();
        read_all();     // first reads stall until the clear sweep ends.
        end_test("clear sweep reads zero");

        start_test();
        drive_traffic(600, 16'hffff, 1'b0);
        pulse_update();
        drain();
        read_all();
        end_test("random traffic with update");

        start_test();
        drive_traffic(400, 16'h5a3c, 1'b0);
        repeat (40) @(posedge clk);
        pulse_update();
        drain();
        read_all();
        end_test("invalid lanes ignored");

        start_test();
        drive_traffic(300, 16'hffff, 1'b0);
        repeat (3 * `STATS_UPDATE_PERIOD) @(posedge clk);
        drain();
        read_all();
        end_test("timed updates only");

        start_test();
        check_value = 1'b0;
        fork
            drive_traffic(600, 16'hffff, 1'b1);
            repeat (3) read_all();
        join
        check_value = 1'b1;
        pulse_update();
        drain();
        read_all();
        end_test("reads under traffic and back-pressure");

        $display("tests run %0d, reads checked %0d, errors %0d", test_no, read_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verilog
verilog/stats_pkg.sv
verilog/stats_collect.sv
verilog/stats_arb.sv
verilog/stats_counter.sv
verilog/stats_top.sv
dv/stats_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the statistics block testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert \
    -f flist.f \
    --top-module stats_tb \
    -Mdir "$build_dir" \
    -o stats_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/stats_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1
